// ==== design/lc3b_params.svh ====
`ifndef LC3B_PARAMS_SVH
`define LC3B_PARAMS_SVH

// first fetch address after reset
`define LC3B_RESET_PC 16'h0040

// general purpose registers r0..r7
`define LC3B_NUM_REGS 8

`endif

// ==== design/lc3b_pkg.sv ====
`default_nettype none

package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// n z p, msb first
	typedef logic [2:0] lc3b_nzp;

	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	typedef enum logic [1:0] {
		alu_pass,
		alu_add,
		alu_and,
		alu_not
	} lc3b_alu_op;

	typedef struct packed {
		lc3b_alu_op alu_op;
		logic imm_sel;
		logic mem_read;
		logic mem_write;
		logic load_regfile;
		logic load_cc;
		logic is_branch;
		// source fields that are really read, for the dependency check
		logic use_sr1;
		logic use_sr2;
		lc3b_reg sr1;
		lc3b_reg sr2;
		lc3b_reg dr;
	} lc3b_control_word;

	typedef struct packed {
		logic valid;
		lc3b_word npc;
		lc3b_word ir;
	} lc3b_fd_latch;

	typedef struct packed {
		logic valid;
		lc3b_control_word cw;
		lc3b_word npc;
		lc3b_word ir;
		lc3b_word sr1_val;
		lc3b_word sr2_val;
		lc3b_nzp cc;
	} lc3b_de_latch;

	typedef struct packed {
		logic valid;
		lc3b_control_word cw;
		lc3b_word result;
		lc3b_word address;
		lc3b_word store_data;
	} lc3b_em_latch;

	typedef struct packed {
		logic valid;
		lc3b_control_word cw;
		lc3b_word data;
	} lc3b_mw_latch;

endpackage : lc3b_pkg

`default_nettype wire

// ==== design/fetch.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "lc3b_params.svh"

module fetch (
	input wire clk,
	input wire rst_n,
	input wire load_fd,
	input wire bubble_fd,
	input wire branch_taken,
	input wire lc3b_pkg::lc3b_word branch_target,
	input wire lc3b_pkg::lc3b_word imem_rdata,
	input wire imem_resp,
	output logic imem_read,
	output lc3b_pkg::lc3b_word imem_address,
	output logic imem_busy,
	output lc3b_pkg::lc3b_fd_latch fd
);

	lc3b_pkg::lc3b_word pc;
	lc3b_pkg::lc3b_word target_q;
	lc3b_pkg::lc3b_word buf_ir;
	logic active;
	logic discard;
	logic buf_valid;
	logic resp_ok;
	logic have;
	logic redirect;
	logic take;

	assign imem_read = active;
	assign imem_address = pc;
	assign resp_ok = active && imem_resp && !discard;
	assign have = buf_valid || resp_ok;
	assign imem_busy = !have;
	// flush only counts when the pipe moves
	assign redirect = branch_taken && load_fd;
	assign take = load_fd && !bubble_fd && have;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= `LC3B_RESET_PC;
			active <= 1'b0;
			discard <= 1'b0;
			buf_valid <= 1'b0;
		end else if (active && imem_resp && discard) begin
			// drop the wrong-path word and restart at the remembered target
			discard <= 1'b0;
			pc <= target_q;
		end else if (redirect) begin
			buf_valid <= 1'b0;
			if (active && !imem_resp) begin
				discard <= 1'b1;
				target_q <= branch_target;
			end else begin
				pc <= branch_target;
				active <= 1'b1;
			end
		end else if (take) begin
			pc <= pc + 16'd2;
			buf_valid <= 1'b0;
			active <= 1'b1;
		end else if (resp_ok) begin
			// decode is stalled, park the word until fd can take it
			buf_valid <= 1'b1;
			buf_ir <= imem_rdata;
			active <= 1'b0;
		end else if (!buf_valid) begin
			active <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fd.valid <= 1'b0;
		end else if (load_fd) begin
			fd.valid <= have && !bubble_fd;
			fd.npc <= pc + 16'd2;
			fd.ir <= buf_valid ? buf_ir : imem_rdata;
		end
	end

endmodule : fetch

`default_nettype wire

// ==== design/decode.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "lc3b_params.svh"

module decode (
	input wire clk,
	input wire rst_n,
	input wire lc3b_pkg::lc3b_fd_latch fd,
	input wire load_de,
	input wire bubble_de,
	input wire wb_load_reg,
	input wire lc3b_pkg::lc3b_reg wb_dr,
	input wire lc3b_pkg::lc3b_word wb_data,
	input wire wb_load_cc,
	input wire lc3b_pkg::lc3b_nzp wb_cc,
	output lc3b_pkg::lc3b_control_word cw,
	output lc3b_pkg::lc3b_de_latch de
);

	lc3b_pkg::lc3b_word regs [`LC3B_NUM_REGS];
	lc3b_pkg::lc3b_nzp cc;
	lc3b_pkg::lc3b_opcode opcode;
	lc3b_pkg::lc3b_word sr1_val;
	lc3b_pkg::lc3b_word sr2_val;
	lc3b_pkg::lc3b_nzp cc_val;

	assign opcode = lc3b_pkg::lc3b_opcode'(fd.ir[15:12]);

	always_comb begin
		cw = '0;
		cw.alu_op = lc3b_pkg::alu_pass;
		cw.sr1 = fd.ir[8:6];
		cw.sr2 = fd.ir[2:0];
		cw.dr = fd.ir[11:9];
		case (opcode)
			lc3b_pkg::op_add, lc3b_pkg::op_and: begin
				if (opcode == lc3b_pkg::op_add) begin
					cw.alu_op = lc3b_pkg::alu_add;
				end else begin
					cw.alu_op = lc3b_pkg::alu_and;
				end
				cw.imm_sel = fd.ir[5];
				cw.use_sr1 = 1'b1;
				cw.use_sr2 = !fd.ir[5];
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
			end
			lc3b_pkg::op_not: begin
				cw.alu_op = lc3b_pkg::alu_not;
				cw.use_sr1 = 1'b1;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
			end
			lc3b_pkg::op_ldr: begin
				cw.mem_read = 1'b1;
				cw.use_sr1 = 1'b1;
				cw.load_regfile = 1'b1;
				cw.load_cc = 1'b1;
			end
			lc3b_pkg::op_str: begin
				// store data comes from the dr field
				cw.mem_write = 1'b1;
				cw.use_sr1 = 1'b1;
				cw.use_sr2 = 1'b1;
				cw.sr2 = fd.ir[11:9];
			end
			lc3b_pkg::op_br: begin
				cw.is_branch = 1'b1;
			end
			default: begin
				cw.alu_op = lc3b_pkg::alu_pass;
			end
		endcase
	end

	// write-first so the retiring value is seen this cycle
	assign sr1_val = (wb_load_reg && wb_dr == cw.sr1) ? wb_data : regs[cw.sr1];
	assign sr2_val = (wb_load_reg && wb_dr == cw.sr2) ? wb_data : regs[cw.sr2];
	assign cc_val = wb_load_cc ? wb_cc : cc;

	always_ff @(posedge clk) begin
		if (wb_load_reg) begin
			regs[wb_dr] <= wb_data;
		end
	end

	// cleared nzp means no branch is taken before the first cc write
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cc <= 3'b000;
		end else if (wb_load_cc) begin
			cc <= wb_cc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			de.valid <= 1'b0;
		end else if (load_de) begin
			de.valid <= fd.valid && !bubble_de;
			de.cw <= cw;
			de.npc <= fd.npc;
			de.ir <= fd.ir;
			de.sr1_val <= sr1_val;
			de.sr2_val <= sr2_val;
			de.cc <= cc_val;
		end
	end

endmodule : decode

`default_nettype wire

// ==== design/execute.sv ====
`default_nettype none
`timescale 1ns/1ns

module execute (
	input wire clk,
	input wire rst_n,
	input wire lc3b_pkg::lc3b_de_latch de,
	input wire load_em,
	output logic branch_taken,
	output lc3b_pkg::lc3b_word branch_target,
	output lc3b_pkg::lc3b_em_latch em
);

	lc3b_pkg::lc3b_word imm5;
	lc3b_pkg::lc3b_word offset6;
	lc3b_pkg::lc3b_word offset9;
	lc3b_pkg::lc3b_word alu_b;
	lc3b_pkg::lc3b_word alu_out;
	lc3b_pkg::lc3b_nzp br_nzp;

	assign imm5 = {{11{de.ir[4]}}, de.ir[4:0]};
	// word offsets, shifted left once
	assign offset6 = {{9{de.ir[5]}}, de.ir[5:0], 1'b0};
	assign offset9 = {{6{de.ir[8]}}, de.ir[8:0], 1'b0};
	assign alu_b = de.cw.imm_sel ? imm5 : de.sr2_val;

	always_comb begin
		case (de.cw.alu_op)
			lc3b_pkg::alu_add: alu_out = de.sr1_val + alu_b;
			lc3b_pkg::alu_and: alu_out = de.sr1_val & alu_b;
			lc3b_pkg::alu_not: alu_out = ~de.sr1_val;
			default: alu_out = de.sr1_val;
		endcase
	end

	assign br_nzp = de.ir[11:9];
	assign branch_target = de.npc + offset9;
	assign branch_taken = de.valid && de.cw.is_branch && |(br_nzp & de.cc);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			em.valid <= 1'b0;
		end else if (load_em) begin
			em.valid <= de.valid;
			em.cw <= de.cw;
			em.result <= alu_out;
			em.address <= de.sr1_val + offset6;
			em.store_data <= de.sr2_val;
		end
	end

endmodule : execute

`default_nettype wire

// ==== design/memory_access.sv ====
`default_nettype none
`timescale 1ns/1ns

module memory_access (
	input wire clk,
	input wire rst_n,
	input wire lc3b_pkg::lc3b_em_latch em,
	input wire load_mw,
	input wire lc3b_pkg::lc3b_word dmem_rdata,
	input wire dmem_resp,
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_pkg::lc3b_word dmem_address,
	output lc3b_pkg::lc3b_word dmem_wdata,
	output logic dmem_busy,
	output lc3b_pkg::lc3b_mw_latch mw,
	output logic wb_load_reg,
	output lc3b_pkg::lc3b_reg wb_dr,
	output lc3b_pkg::lc3b_word wb_data,
	output logic wb_load_cc,
	output lc3b_pkg::lc3b_nzp wb_cc
);

	logic access;

	assign access = em.valid && (em.cw.mem_read || em.cw.mem_write);
	assign dmem_read = access && em.cw.mem_read;
	assign dmem_write = access && em.cw.mem_write;
	assign dmem_address = em.address;
	assign dmem_wdata = em.store_data;
	assign dmem_busy = access && !dmem_resp;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mw.valid <= 1'b0;
		end else if (load_mw) begin
			mw.valid <= em.valid;
			mw.cw <= em.cw;
			mw.data <= em.cw.mem_read ? dmem_rdata : em.result;
		end
	end

	assign wb_load_reg = mw.valid && mw.cw.load_regfile;
	assign wb_dr = mw.cw.dr;
	assign wb_data = mw.data;
	assign wb_load_cc = mw.valid && mw.cw.load_cc;

	always_comb begin
		if (mw.data[15]) begin
			wb_cc = 3'b100;
		end else if (mw.data == 16'h0000) begin
			wb_cc = 3'b010;
		end else begin
			wb_cc = 3'b001;
		end
	end

endmodule : memory_access

`default_nettype wire

// ==== design/hazard_control.sv ====
`default_nettype none
`timescale 1ns/1ns

module hazard_control (
	input wire lc3b_pkg::lc3b_control_word cw,
	input wire fd_valid,
	input wire lc3b_pkg::lc3b_de_latch de,
	input wire lc3b_pkg::lc3b_em_latch em,
	input wire lc3b_pkg::lc3b_mw_latch mw,
	input wire imem_busy,
	input wire dmem_busy,
	input wire branch_taken,
	output logic load_fd,
	output logic bubble_fd,
	output logic load_de,
	output logic bubble_de,
	output logic load_em,
	output logic load_mw
);

	logic dep_stall;

	// does the younger instruction need a result the older one has not written
	function automatic logic depends(
		input logic older_valid,
		input lc3b_pkg::lc3b_control_word older,
		input lc3b_pkg::lc3b_control_word younger
	);
		logic src1;
		logic src2;
		src1 = younger.use_sr1 && (younger.sr1 == older.dr);
		src2 = younger.use_sr2 && (younger.sr2 == older.dr);
		return older_valid && ((older.load_regfile && (src1 || src2)) ||
			(older.load_cc && younger.is_branch));
	endfunction

	// mw writes back in the same cycle and decode reads write-first
	assign dep_stall = fd_valid && (depends(de.valid, de.cw, cw) ||
		depends(em.valid, em.cw, cw));

	always_comb begin
		load_fd = 1'b1;
		bubble_fd = 1'b0;
		load_de = 1'b1;
		bubble_de = 1'b0;
		load_em = 1'b1;
		load_mw = 1'b1;
		if (dmem_busy) begin
			// whole pipe frozen
			load_fd = 1'b0;
			load_de = 1'b0;
			load_em = 1'b0;
			load_mw = 1'b0;
		end else if (branch_taken) begin
			bubble_fd = 1'b1;
			bubble_de = 1'b1;
		end else if (dep_stall) begin
			load_fd = 1'b0;
			bubble_de = 1'b1;
		end else if (imem_busy) begin
			bubble_fd = 1'b1;
		end
	end

endmodule : hazard_control

`default_nettype wire

// ==== design/mp3.sv ====
`default_nettype none
`timescale 1ns/1ns

module mp3 (
	input wire clk,
	input wire rst_n,

	// instruction port
	output logic imem_read,
	output lc3b_pkg::lc3b_word imem_address,
	input wire lc3b_pkg::lc3b_word imem_rdata,
	input wire imem_resp,

	// data port
	output logic dmem_read,
	output logic dmem_write,
	output lc3b_pkg::lc3b_word dmem_address,
	output lc3b_pkg::lc3b_word dmem_wdata,
	input wire lc3b_pkg::lc3b_word dmem_rdata,
	input wire dmem_resp
);

	lc3b_pkg::lc3b_fd_latch fd;
	lc3b_pkg::lc3b_de_latch de;
	lc3b_pkg::lc3b_em_latch em;
	lc3b_pkg::lc3b_mw_latch mw;
	lc3b_pkg::lc3b_control_word cw;
	lc3b_pkg::lc3b_word branch_target;
	logic branch_taken;
	logic imem_busy;
	logic dmem_busy;

	logic load_fd;
	logic bubble_fd;
	logic load_de;
	logic bubble_de;
	logic load_em;
	logic load_mw;

	// register and cc write from the last stage
	logic wb_load_reg;
	lc3b_pkg::lc3b_reg wb_dr;
	lc3b_pkg::lc3b_word wb_data;
	logic wb_load_cc;
	lc3b_pkg::lc3b_nzp wb_cc;

	fetch fetch_int (
		.clk, .rst_n, .load_fd, .bubble_fd, .branch_taken, .branch_target,
		.imem_rdata, .imem_resp, .imem_read, .imem_address, .imem_busy, .fd
	);

	decode decode_int (
		.clk, .rst_n, .fd, .load_de, .bubble_de,
		.wb_load_reg, .wb_dr, .wb_data, .wb_load_cc, .wb_cc, .cw, .de
	);

	execute execute_int (
		.clk, .rst_n, .de, .load_em, .branch_taken, .branch_target, .em
	);

	memory_access memory_access_int (
		.clk, .rst_n, .em, .load_mw, .dmem_rdata, .dmem_resp,
		.dmem_read, .dmem_write, .dmem_address, .dmem_wdata, .dmem_busy, .mw,
		.wb_load_reg, .wb_dr, .wb_data, .wb_load_cc, .wb_cc
	);

	hazard_control hazard_control_int (
		.cw, .fd_valid(fd.valid), .de, .em, .mw,
		.imem_busy, .dmem_busy, .branch_taken,
		.load_fd, .bubble_fd, .load_de, .bubble_de, .load_em, .load_mw
	);

endmodule : mp3

`default_nettype wire

// ==== sim/mp3_mem_model.sv ====
`default_nettype none
`timescale 1ns/1ns

module mp3_mem_model (
	input wire clk,
	input wire rst_n,
	input wire imem_read,
	input wire lc3b_pkg::lc3b_word imem_address,
	output lc3b_pkg::lc3b_word imem_rdata,
	output logic imem_resp,
	input wire dmem_read,
	input wire dmem_write,
	input wire lc3b_pkg::lc3b_word dmem_address,
	input wire lc3b_pkg::lc3b_word dmem_wdata,
	output lc3b_pkg::lc3b_word dmem_rdata,
	output logic dmem_resp
);

	// one shared word array, indexed by byte address bits 15:1
	lc3b_pkg::lc3b_word ram [32768];
	int imem_wait;
	int dmem_wait;

	initial begin
		for (int i = 0; i < 32768; i++) begin
			ram[i] = {i[14:0], 1'b0} ^ 16'hb6d3;
		end
		imem_rdata = 16'h0000;
		imem_resp = 1'b0;
		dmem_rdata = 16'h0000;
		dmem_resp = 1'b0;
		imem_wait = -1;
		dmem_wait = -1;
	end

	task automatic load_word(input lc3b_pkg::lc3b_word address, input lc3b_pkg::lc3b_word data);
		ram[address[15:1]] = data;
	endtask

	// instruction port, resp is a one-cycle pulse after 0..3 wait cycles
	always @(posedge clk) begin
		#1;
		if (!rst_n || imem_resp) begin
			imem_resp = 1'b0;
			imem_wait = -1;
		end else if (imem_read) begin
			if (imem_wait < 0) begin
				imem_wait = $urandom_range(3, 0);
			end
			if (imem_wait == 0) begin
				imem_rdata = ram[imem_address[15:1]];
				imem_resp = 1'b1;
				imem_wait = -1;
			end else begin
				imem_wait = imem_wait - 1;
			end
		end else begin
			imem_wait = -1;
		end
	end

	always @(posedge clk) begin
		#1;
		if (!rst_n || dmem_resp) begin
			dmem_resp = 1'b0;
			dmem_wait = -1;
		end else if (dmem_read || dmem_write) begin
			if (dmem_wait < 0) begin
				dmem_wait = $urandom_range(3, 0);
			end
			if (dmem_wait == 0) begin
				if (dmem_write) begin
					ram[dmem_address[15:1]] = dmem_wdata;
				end else begin
					dmem_rdata = ram[dmem_address[15:1]];
				end
				dmem_resp = 1'b1;
				dmem_wait = -1;
			end else begin
				dmem_wait = dmem_wait - 1;
			end
		end else begin
			dmem_wait = -1;
		end
	end

endmodule : mp3_mem_model

`default_nettype wire

// ==== sim/mp3_tb.sv ====
`default_nettype none
`timescale 1ns/1ns
`include "lc3b_params.svh"

module mp3_tb;

	logic clk;
	logic rst_n;
	logic imem_read;
	lc3b_pkg::lc3b_word imem_address;
	lc3b_pkg::lc3b_word imem_rdata;
	logic imem_resp;
	logic dmem_read;
	logic dmem_write;
	lc3b_pkg::lc3b_word dmem_address;
	lc3b_pkg::lc3b_word dmem_wdata;
	lc3b_pkg::lc3b_word dmem_rdata;
	logic dmem_resp;

	lc3b_pkg::lc3b_word prog [$];
	lc3b_pkg::lc3b_word exp_addr [$];
	lc3b_pkg::lc3b_word exp_data [$];
	lc3b_pkg::lc3b_word ref_mem [32768];
	int mismatches = 0;
	int other_errors = 0;
	int stores_checked = 0;

	mp3 uut (
		.clk, .rst_n, .imem_read, .imem_address, .imem_rdata, .imem_resp,
		.dmem_read, .dmem_write, .dmem_address, .dmem_wdata, .dmem_rdata, .dmem_resp
	);

	mp3_mem_model mem (
		.clk, .rst_n, .imem_read, .imem_address, .imem_rdata, .imem_resp,
		.dmem_read, .dmem_write, .dmem_address, .dmem_wdata, .dmem_rdata, .dmem_resp
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	function automatic lc3b_pkg::lc3b_word reg_form(lc3b_pkg::lc3b_opcode op, int dr, int sr1,
		int sr2);
		return {op, 3'(dr), 3'(sr1), 3'b000, 3'(sr2)};
	endfunction

	function automatic lc3b_pkg::lc3b_word imm_form(lc3b_pkg::lc3b_opcode op, int dr, int sr1,
		int imm);
		return {op, 3'(dr), 3'(sr1), 1'b1, 5'(imm)};
	endfunction

	function automatic lc3b_pkg::lc3b_word not_instr(int dr, int sr);
		return {lc3b_pkg::op_not, 3'(dr), 3'(sr), 6'b111111};
	endfunction

	// LDR and STR, offset counted in words
	function automatic lc3b_pkg::lc3b_word mem_form(lc3b_pkg::lc3b_opcode op, int r, int base,
		int off6);
		return {op, 3'(r), 3'(base), 6'(off6)};
	endfunction

	function automatic lc3b_pkg::lc3b_word branch_instr(int nzp, int off9);
		return {lc3b_pkg::op_br, 3'(nzp), 9'(off9)};
	endfunction

	function automatic lc3b_pkg::lc3b_nzp cond_code(input lc3b_pkg::lc3b_word value);
		if (value[15]) begin
			return 3'b100;
		end else if (value == 16'h0000) begin
			return 3'b010;
		end
		return 3'b001;
	endfunction

	task automatic build_program;
		// r7 stays zero, stores go below the code
		prog.push_back(imm_form(lc3b_pkg::op_and, 7, 7, 0));
		prog.push_back(imm_form(lc3b_pkg::op_and, 1, 1, 0));
		prog.push_back(imm_form(lc3b_pkg::op_add, 1, 1, 7));
		prog.push_back(imm_form(lc3b_pkg::op_and, 2, 2, 0));
		prog.push_back(imm_form(lc3b_pkg::op_add, 2, 2, -3));
		prog.push_back(reg_form(lc3b_pkg::op_add, 3, 1, 2));
		prog.push_back(mem_form(lc3b_pkg::op_str, 3, 7, 0));
		prog.push_back(reg_form(lc3b_pkg::op_and, 4, 1, 2));
		prog.push_back(not_instr(5, 4));
		prog.push_back(mem_form(lc3b_pkg::op_str, 5, 7, 1));
		prog.push_back(imm_form(lc3b_pkg::op_and, 6, 5, 14));
		prog.push_back(mem_form(lc3b_pkg::op_str, 4, 7, 2));
		prog.push_back(mem_form(lc3b_pkg::op_str, 6, 7, 3));
		// chain at distance 1 and 2
		prog.push_back(imm_form(lc3b_pkg::op_add, 1, 1, 1));
		prog.push_back(reg_form(lc3b_pkg::op_add, 2, 1, 1));
		prog.push_back(reg_form(lc3b_pkg::op_add, 5, 2, 1));
		// load then use
		prog.push_back(mem_form(lc3b_pkg::op_ldr, 0, 7, 0));
		prog.push_back(reg_form(lc3b_pkg::op_add, 0, 0, 5));
		prog.push_back(mem_form(lc3b_pkg::op_str, 0, 7, 4));
		// branches taken and not taken
		prog.push_back(imm_form(lc3b_pkg::op_and, 1, 1, 0));
		prog.push_back(branch_instr(3'b010, 1));
		prog.push_back(mem_form(lc3b_pkg::op_str, 5, 7, 5));
		prog.push_back(branch_instr(3'b100, 1));
		prog.push_back(mem_form(lc3b_pkg::op_str, 0, 7, 6));
		prog.push_back(imm_form(lc3b_pkg::op_add, 2, 1, -1));
		prog.push_back(branch_instr(3'b100, 1));
		prog.push_back(mem_form(lc3b_pkg::op_str, 2, 7, 7));
		prog.push_back(mem_form(lc3b_pkg::op_str, 2, 7, 8));
		// short backward loop, two passes
		prog.push_back(imm_form(lc3b_pkg::op_and, 6, 6, 0));
		prog.push_back(imm_form(lc3b_pkg::op_add, 6, 6, 2));
		prog.push_back(imm_form(lc3b_pkg::op_add, 6, 6, -1));
		prog.push_back(mem_form(lc3b_pkg::op_str, 6, 7, 9));
		prog.push_back(branch_instr(3'b001, -3));
		prog.push_back(branch_instr(3'b111, -1));
		prog.push_back(16'h0000);
		prog.push_back(16'h0000);
	endtask

	// sequential ISA model, queues every store it makes
	task automatic run_reference;
		lc3b_pkg::lc3b_word gpr [8];
		lc3b_pkg::lc3b_word pc;
		lc3b_pkg::lc3b_word ir;
		lc3b_pkg::lc3b_word operand;
		lc3b_pkg::lc3b_word addr;
		lc3b_pkg::lc3b_word target;
		lc3b_pkg::lc3b_nzp cc;
		int steps;
		logic halted;
		for (int i = 0; i < 32768; i++) begin
			ref_mem[i] = mem.ram[i];
		end
		for (int i = 0; i < 8; i++) begin
			gpr[i] = 16'h0000;
		end
		pc = `LC3B_RESET_PC;
		cc = 3'b000;
		steps = 0;
		halted = 1'b0;
		while (!halted && steps < 1000) begin
			ir = ref_mem[pc[15:1]];
			pc = pc + 16'd2;
			operand = ir[5] ? {{11{ir[4]}}, ir[4:0]} : gpr[ir[2:0]];
			addr = gpr[ir[8:6]] + {{9{ir[5]}}, ir[5:0], 1'b0};
			case (ir[15:12])
				lc3b_pkg::op_add: gpr[ir[11:9]] = gpr[ir[8:6]] + operand;
				lc3b_pkg::op_and: gpr[ir[11:9]] = gpr[ir[8:6]] & operand;
				lc3b_pkg::op_not: gpr[ir[11:9]] = ~gpr[ir[8:6]];
				lc3b_pkg::op_ldr: gpr[ir[11:9]] = ref_mem[addr[15:1]];
				lc3b_pkg::op_str: begin
					ref_mem[addr[15:1]] = gpr[ir[11:9]];
					exp_addr.push_back(addr);
					exp_data.push_back(gpr[ir[11:9]]);
				end
				lc3b_pkg::op_br: begin
					target = pc + {{6{ir[8]}}, ir[8:0], 1'b0};
					if ((ir[11:9] & cc) != 3'b000) begin
						halted = (target == pc - 16'd2);
						pc = target;
					end
				end
				default: ;
			endcase
			if (ir[15:12] inside {lc3b_pkg::op_add, lc3b_pkg::op_and, lc3b_pkg::op_not,
				lc3b_pkg::op_ldr}) begin
				cc = cond_code(gpr[ir[11:9]]);
			end
			steps++;
		end
		if (!halted) begin
			$display("reference model did not reach the final loop");
			other_errors++;
		end
	endtask

	task automatic apply_reset;
		rst_n = 1'b0;
		repeat (8) begin
			@(posedge clk);
			#1;
			quiet_in_reset: assert (!imem_read && !dmem_read && !dmem_write) else begin
				$display("a memory strobe was high during reset at %0t", $time);
				other_errors++;
			end
		end
		rst_n = 1'b1;
	endtask

	task automatic check_first_fetch;
		int cycles;
		cycles = 0;
		while (!imem_read && cycles < 10) begin
			@(posedge clk);
			#1;
			cycles++;
		end
		if (!imem_read) begin
			$display("no instruction fetch started after reset");
			other_errors++;
		end else begin
			first_fetch_pc: assert (imem_address == `LC3B_RESET_PC) else begin
				$display("Mismatch at %0t: imem_address is %h, expected %h", $time,
					imem_address, `LC3B_RESET_PC);
				mismatches++;
			end
		end
	endtask

	task automatic finish_run;
		if (exp_addr.size() != 0) begin
			$display("%0d expected stores never appeared", exp_addr.size());
			other_errors++;
		end
		$display("%0d stores checked, %0d mismatches, %0d other errors", stores_checked,
			mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	endtask

	// stores are compared in the cycle the port accepts them
	always @(negedge clk) begin
		if (rst_n && dmem_write && dmem_resp) begin
			if (exp_addr.size() == 0) begin
				$display("unexpected store of %h to %h at %0t", dmem_wdata, dmem_address, $time);
				other_errors++;
			end else begin
				store_address: assert (dmem_address == exp_addr[0]) else begin
					$display("Mismatch at %0t: dmem_address is %h, expected %h", $time,
						dmem_address, exp_addr[0]);
					mismatches++;
				end
				store_data: assert (dmem_wdata == exp_data[0]) else begin
					$display("Mismatch at %0t: dmem_wdata is %h, expected %h", $time,
						dmem_wdata, exp_data[0]);
					mismatches++;
				end
				exp_addr.delete(0);
				exp_data.delete(0);
				stores_checked++;
			end
		end
	end

	read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmem_read && dmem_write)) else begin
		$display("dmem_read and dmem_write were high together at %0t", $time);
		other_errors++;
	end

	load_held: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_read && !dmem_resp) |=> (dmem_read && $stable(dmem_address))) else begin
		$display("dmem_read dropped or its address moved before resp at %0t", $time);
		other_errors++;
	end

	store_held: assert property (@(posedge clk) disable iff (!rst_n)
		(dmem_write && !dmem_resp) |=>
		(dmem_write && $stable(dmem_address) && $stable(dmem_wdata))) else begin
		$display("dmem_write dropped or its address or data moved before resp at %0t", $time);
		other_errors++;
	end

	fetch_held: assert property (@(posedge clk) disable iff (!rst_n)
		(imem_read && !imem_resp) |=> (imem_read && $stable(imem_address))) else begin
		$display("imem_read dropped or its address moved before resp at %0t", $time);
		other_errors++;
	end

	initial begin
		rst_n = 1'b0;
		void'($urandom(96971));
		build_program();
		// memory fill runs at time zero, the image goes on top of it
		#2;
		foreach (prog[i]) begin
			mem.load_word(`LC3B_RESET_PC + 16'(2 * i), prog[i]);
		end
		run_reference();
		apply_reset();
		check_first_fetch();
		while (exp_addr.size() != 0) begin
			@(posedge clk);
		end
		// watch for stray stores after the last one
		repeat (50) @(posedge clk);
		finish_run();
	end

	// 40 cycles per program word
	initial begin
		#1;
		repeat (40 * prog.size()) @(posedge clk);
		$display("timeout, the program did not finish its stores in time");
		other_errors++;
		finish_run();
	end

endmodule : mp3_tb

`default_nettype wire

// ==== files.f ====
+incdir+design
design/lc3b_pkg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memory_access.sv
design/hazard_control.sv
design/mp3.sv
sim/mp3_mem_model.sv
sim/mp3_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module mp3_tb -f files.f \
	-Mdir obj_dir -o mp3_sim \
	&& ./obj_dir/mp3_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
